/* include/fe_cfg.svh */
`ifndef FE_CFG_SVH
`define FE_CFG_SVH

// first fetch address out of reset
`define FE_RESET_PC   32'h0000_1000
`define FE_FIFO_DEPTH 4
`define FE_EPOCH_W    2

// major opcodes, inst[31:26]
`define FE_OP_ALU_RR  6'b000000
`define FE_OP_ALU_RI  6'b000010
`define FE_OP_STORE   6'b001010
`define FE_OP_BRANCH  6'b010110
`define FE_OP_BL      6'b010101

`endif

/* rtl/fe_pkg.sv */
`include "fe_cfg.svh"

package fe_pkg;

  typedef enum logic [2:0] {
    CLS_ALU_RR  = 3'd0,
    CLS_ALU_RI  = 3'd1,
    CLS_STORE   = 3'd2,
    CLS_BRANCH  = 3'd3,
    CLS_BL      = 3'd4,
    CLS_ILLEGAL = 3'd5
  } inst_cls_e;

  // pcgen to fetch, pc is 8-byte aligned
  typedef struct packed {
    logic [31:0]            pc;
    logic [1:0]             mask;
    logic [`FE_EPOCH_W-1:0] epoch;
  } fetch_req_t;

  // fetch to decode
  // inst[0] sits at pc+0, inst[1] at pc+4
  typedef struct packed {
    logic [31:0]      pc;
    logic [1:0][31:0] inst;
    logic [1:0]       mask;
  } fetch_grp_t;

  typedef struct packed {
    inst_cls_e  cls;
    logic       ine;
    logic [4:0] r0;
    logic [4:0] r1;
    logic [4:0] w;
  } slot_info_t;

  // decoded packet as held in the packet fifo
  typedef struct packed {
    logic [31:0]      pc;
    logic [1:0]       mask;
    slot_info_t [1:0] slot;
  } fe_pkt_t;

endpackage

/* rtl/fe_ctrl.sv */
`timescale 1ns/10ps
`include "fe_cfg.svh"

module fe_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   redirect_i,
  input  logic [31:0]            redirect_pc_i,
  input  logic                   cyc_start_i,
  input  logic                   ack_i,
  input  logic [`FE_EPOCH_W-1:0] ack_epoch_i,
  output logic                   flush_o,
  output logic                   load_o,
  output logic [31:0]            next_pc_o,
  output logic [`FE_EPOCH_W-1:0] epoch_o,
  output logic                   keep_o
);

  logic                   redir_q;
  logic [31:0]            redir_pc_q;
  logic [`FE_EPOCH_W-1:0] epoch_q;
  logic                   cyc_open_q;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      redir_q    <= 1'b0;
      epoch_q    <= '0;
      cyc_open_q <= 1'b0;
    end
    else
    begin
      redir_q <= redirect_i;
      // new epoch takes effect together with the pc load
      if (redir_q)
        epoch_q <= epoch_q + 1'b1;
      // a classic cycle runs to its ack even across a flush
      if (cyc_start_i)
        cyc_open_q <= 1'b1;
      else if (ack_i)
        cyc_open_q <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (redirect_i)
      redir_pc_q <= redirect_pc_i;
  end

  assign flush_o   = redir_q;
  assign load_o    = redir_q;
  assign next_pc_o = redir_pc_q;
  assign epoch_o   = epoch_q;

  // groups tagged with an older epoch were requested before the redirect
  assign keep_o = cyc_open_q && (ack_epoch_i == epoch_q);

  a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    ack_i |-> cyc_open_q);

endmodule

/* rtl/fe_pcgen.sv */
`timescale 1ns/10ps
`include "fe_cfg.svh"

module fe_pcgen import fe_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   load_i,
  input  logic [31:0]            next_pc_i,
  input  logic [`FE_EPOCH_W-1:0] epoch_i,
  output fetch_req_t             req_o,
  output logic                   valid_o,
  input  logic                   ready_i
);

  logic [31:0] pc_q;
  logic        valid_q;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      pc_q    <= `FE_RESET_PC;
      valid_q <= 1'b0;
    end
    else
    begin
      valid_q <= 1'b1;
      if (load_i)
        pc_q <= next_pc_i;
      else if (valid_o && ready_i)
        pc_q <= {pc_q[31:3], 3'b000} + 32'd8;
    end
  end

  // no request while the redirect target is being loaded
  assign valid_o = valid_q && !load_i;

  assign req_o.pc    = {pc_q[31:3], 3'b000};
  assign req_o.mask  = pc_q[2] ? 2'b10 : 2'b11;
  assign req_o.epoch = epoch_i;

endmodule

/* rtl/fe_skid_buf.sv */
`timescale 1ns/10ps

module fe_skid_buf #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic rst_n,
  input  logic flush_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  logic ready_q;
  T     hold_q;

  // ready drops one cycle after a stall, the hold register catches the beat
  always_ff @(posedge clk)
  begin
    if (!rst_n || flush_i)
      ready_q <= 1'b1;
    else
      ready_q <= !(valid_o && !ready_i);
  end

  always_ff @(posedge clk)
  begin
    if (ready_q)
      hold_q <= data_i;
  end

  assign ready_o = ready_q;
  assign valid_o = valid_i || !ready_q;
  assign data_o  = ready_q ? data_i : hold_q;

  a_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
    valid_o && !ready_i && !flush_i |=> $stable(data_o));

endmodule

/* rtl/fe_wb_fetch.sv */
`timescale 1ns/10ps
`include "fe_cfg.svh"

module fe_wb_fetch import fe_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush_i,
  input  fetch_req_t             req_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  logic                   keep_i,
  output logic                   cyc_start_o,
  output logic                   ack_o,
  output logic [`FE_EPOCH_W-1:0] ack_epoch_o,
  output fetch_grp_t             grp_o,
  output logic                   grp_valid_o,
  input  logic                   grp_ready_i,
  output logic                   wb_cyc_o,
  output logic                   wb_stb_o,
  output logic [31:0]            wb_adr_o,
  input  logic [63:0]            wb_dat_i,
  input  logic                   wb_ack_i
);

  logic       cyc_q;
  logic       grp_valid_q;
  fetch_req_t req_q;
  fetch_grp_t grp_q;
  logic       take;

  // one request in flight, none while a group still waits
  assign req_ready_o = !cyc_q && !grp_valid_q;
  assign take        = req_valid_i && req_ready_o;
  assign cyc_start_o = take;
  assign ack_o       = cyc_q && wb_ack_i;
  assign ack_epoch_o = req_q.epoch;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      cyc_q       <= 1'b0;
      grp_valid_q <= 1'b0;
    end
    else
    begin
      if (take)
        cyc_q <= 1'b1;
      else if (ack_o)
        cyc_q <= 1'b0;
      // stale data is dropped here and never leaves the stage
      if (flush_i)
        grp_valid_q <= 1'b0;
      else if (ack_o)
        grp_valid_q <= keep_i;
      else if (grp_ready_i)
        grp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (take)
      req_q <= req_i;
    if (ack_o)
    begin
      grp_q.pc   <= req_q.pc;
      grp_q.inst <= wb_dat_i;
      grp_q.mask <= req_q.mask;
    end
  end

  assign grp_o       = grp_q;
  assign grp_valid_o = grp_valid_q;

  assign wb_cyc_o = cyc_q;
  assign wb_stb_o = cyc_q;
  assign wb_adr_o = req_q.pc;

  a_stb_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
    wb_stb_o && !wb_ack_i |=> wb_stb_o);

endmodule

/* rtl/fe_decode.sv */
`timescale 1ns/10ps
`include "fe_cfg.svh"

module fe_decode import fe_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       flush_i,
  input  fetch_grp_t grp_i,
  input  logic       valid_i,
  output logic       ready_o,
  output fe_pkt_t    pkt_o,
  output logic       valid_o,
  input  logic       ready_i
);

  function automatic slot_info_t decode_slot(input logic [31:0] inst);
    slot_info_t s;
    s = '0;
    case (inst[31:26])
      `FE_OP_ALU_RR:
      begin
        s.cls = CLS_ALU_RR;
        s.r0  = inst[14:10];
        s.r1  = inst[9:5];
        s.w   = inst[4:0];
      end
      `FE_OP_ALU_RI:
      begin
        s.cls = CLS_ALU_RI;
        s.r1  = inst[9:5];
        s.w   = inst[4:0];
      end
      `FE_OP_STORE, `FE_OP_BRANCH:
      begin
        s.cls = (inst[31:26] == `FE_OP_STORE) ? CLS_STORE : CLS_BRANCH;
        // rd is a source here
        s.r0  = inst[4:0];
        s.r1  = inst[9:5];
      end
      `FE_OP_BL:
      begin
        s.cls = CLS_BL;
        s.w   = 5'd1;
      end
      default:
      begin
        s.cls = CLS_ILLEGAL;
        s.ine = 1'b1;
      end
    endcase
    return s;
  endfunction

  fe_pkt_t pkt_d;
  fe_pkt_t pkt_q;
  logic    valid_q;

  assign pkt_d.pc      = grp_i.pc;
  assign pkt_d.mask    = grp_i.mask;
  assign pkt_d.slot[0] = decode_slot(grp_i.inst[0]);
  assign pkt_d.slot[1] = decode_slot(grp_i.inst[1]);

  assign ready_o = !valid_q || ready_i;

  always_ff @(posedge clk)
  begin
    if (!rst_n || flush_i)
      valid_q <= 1'b0;
    else if (ready_o)
      valid_q <= valid_i;
  end

  always_ff @(posedge clk)
  begin
    if (ready_o && valid_i)
      pkt_q <= pkt_d;
  end

  assign pkt_o   = pkt_q;
  assign valid_o = valid_q;

endmodule

/* rtl/fe_pkt_fifo.sv */
`timescale 1ns/10ps
`include "fe_cfg.svh"

module fe_pkt_fifo import fe_pkg::*; #(
  parameter int DEPTH = `FE_FIFO_DEPTH
) (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    flush_i,
  input  fe_pkt_t wr_data_i,
  input  logic    wr_valid_i,
  output logic    wr_ready_o,
  output fe_pkt_t rd_data_o,
  output logic    rd_valid_o,
  input  logic    rd_ready_i
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  fe_pkt_t        mem_q [DEPTH];
  logic [AW-1:0]  wr_ptr_q;
  logic [AW-1:0]  rd_ptr_q;
  logic [AW:0]    count_q;
  logic           push;
  logic           pop;

  assign wr_ready_o = (count_q != (AW+1)'(DEPTH));
  // entries still held during the flush cycle belong to the old path
  assign rd_valid_o = (count_q != '0) && !flush_i;
  assign rd_data_o  = mem_q[rd_ptr_q];

  assign push = wr_valid_i && wr_ready_o;
  assign pop  = rd_valid_o && rd_ready_i;

  always_ff @(posedge clk)
  begin
    if (!rst_n || flush_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (push && !pop)
        count_q <= count_q + 1'b1;
      else if (pop && !push)
        count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem_q[wr_ptr_q] <= wr_data_i;
  end

  a_count_max: assert property (@(posedge clk) disable iff (!rst_n)
    count_q <= (AW+1)'(DEPTH));

endmodule

/* rtl/fe_top.sv */
`timescale 1ns/10ps
`include "fe_cfg.svh"

module fe_top import fe_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  redirect_i,
  input  logic [31:0]           redirect_pc_i,
  output logic                  wb_cyc_o,
  output logic                  wb_stb_o,
  output logic [31:0]           wb_adr_o,
  input  logic [63:0]           wb_dat_i,
  input  logic                  wb_ack_i,
  output logic                  pkg_valid_o,
  input  logic                  pkg_ready_i,
  output logic [31:0]           pkg_pc_o,
  output logic [1:0]            pkg_mask_o,
  output inst_cls_e [1:0]       pkg_cls_o,
  output logic [1:0]            pkg_ine_o,
  output logic [1:0][4:0]       pkg_r0_o,
  output logic [1:0][4:0]       pkg_r1_o,
  output logic [1:0][4:0]       pkg_w_o
);

  logic                   flush;
  logic                   load;
  logic [31:0]            next_pc;
  logic [`FE_EPOCH_W-1:0] epoch;
  logic                   keep;
  logic                   cyc_start;
  logic                   ack;
  logic [`FE_EPOCH_W-1:0] ack_epoch;

  fetch_req_t pg_req;
  logic       pg_valid;
  logic       pg_ready;
  fetch_req_t sa_req;
  logic       sa_valid;
  logic       sa_ready;
  fetch_grp_t wf_grp;
  logic       wf_valid;
  logic       wf_ready;
  fetch_grp_t sb_grp;
  logic       sb_valid;
  logic       sb_ready;
  fe_pkt_t    dc_pkt;
  logic       dc_valid;
  logic       dc_ready;
  fe_pkt_t    out_pkt;

  fe_ctrl ctrl_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .cyc_start_i   (cyc_start),
    .ack_i         (ack),
    .ack_epoch_i   (ack_epoch),
    .flush_o       (flush),
    .load_o        (load),
    .next_pc_o     (next_pc),
    .epoch_o       (epoch),
    .keep_o        (keep)
  );

  fe_pcgen pcgen_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .load_i    (load),
    .next_pc_i (next_pc),
    .epoch_i   (epoch),
    .req_o     (pg_req),
    .valid_o   (pg_valid),
    .ready_i   (pg_ready)
  );

  fe_skid_buf #(.T(fetch_req_t)) skid_a_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (flush),
    .valid_i (pg_valid),
    .ready_o (pg_ready),
    .data_i  (pg_req),
    .valid_o (sa_valid),
    .ready_i (sa_ready),
    .data_o  (sa_req)
  );

  fe_wb_fetch fetch_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush),
    .req_i       (sa_req),
    .req_valid_i (sa_valid),
    .req_ready_o (sa_ready),
    .keep_i      (keep),
    .cyc_start_o (cyc_start),
    .ack_o       (ack),
    .ack_epoch_o (ack_epoch),
    .grp_o       (wf_grp),
    .grp_valid_o (wf_valid),
    .grp_ready_i (wf_ready),
    .wb_cyc_o    (wb_cyc_o),
    .wb_stb_o    (wb_stb_o),
    .wb_adr_o    (wb_adr_o),
    .wb_dat_i    (wb_dat_i),
    .wb_ack_i    (wb_ack_i)
  );

  fe_skid_buf #(.T(fetch_grp_t)) skid_b_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (flush),
    .valid_i (wf_valid),
    .ready_o (wf_ready),
    .data_i  (wf_grp),
    .valid_o (sb_valid),
    .ready_i (sb_ready),
    .data_o  (sb_grp)
  );

  fe_decode decode_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (flush),
    .grp_i   (sb_grp),
    .valid_i (sb_valid),
    .ready_o (sb_ready),
    .pkt_o   (dc_pkt),
    .valid_o (dc_valid),
    .ready_i (dc_ready)
  );

  fe_pkt_fifo #(.DEPTH(`FE_FIFO_DEPTH)) fifo_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush),
    .wr_data_i  (dc_pkt),
    .wr_valid_i (dc_valid),
    .wr_ready_o (dc_ready),
    .rd_data_o  (out_pkt),
    .rd_valid_o (pkg_valid_o),
    .rd_ready_i (pkg_ready_i)
  );

  assign pkg_pc_o   = out_pkt.pc;
  assign pkg_mask_o = out_pkt.mask;

  for (genvar i = 0; i < 2; i++)
  begin : g_slot
    assign pkg_cls_o[i] = out_pkt.slot[i].cls;
    assign pkg_ine_o[i] = out_pkt.slot[i].ine;
    assign pkg_r0_o[i]  = out_pkt.slot[i].r0;
    assign pkg_r1_o[i]  = out_pkt.slot[i].r1;
    assign pkg_w_o[i]   = out_pkt.slot[i].w;
  end

endmodule

/* testbench/tb_clkgen.sv */
`timescale 1ns/10ps

module tb_clkgen #(
  parameter int HALF_NS    = 2,
  parameter int RST_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #(HALF_NS) clk_o = ~clk_o;
  end

  // release on a falling edge, like every other driven input
  initial
  begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* testbench/tb_wb_mem.sv */
`timescale 1ns/10ps

module tb_wb_mem (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [63:0] image_i [64],
  input  logic        wait_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic [31:0] wb_adr_i,
  output logic [63:0] wb_dat_o,
  output logic        wb_ack_o
);

  initial
  begin
    wb_ack_o = 1'b0;
    wb_dat_o = '0;
  end

  // registered ack, one cycle after stb at the earliest
  // wait_i holds the ack off for another cycle
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      wb_ack_o <= 1'b0;
      wb_dat_o <= '0;
    end
    else if (wb_cyc_i && wb_stb_i && !wb_ack_o && !wait_i)
    begin
      wb_ack_o <= 1'b1;
      wb_dat_o <= image_i[wb_adr_i[8:3]];
    end
    else
      wb_ack_o <= 1'b0;
  end

endmodule

/* testbench/tb_fe_top.sv */
`timescale 1ns/10ps
`include "fe_cfg.svh"

module tb_fe_top import fe_pkg::*; ();

  localparam int CLK_NS      = 4;
  localparam int CYC_PER_PKT = 40;

  typedef struct packed {
    logic [1:0]  redir;    // 0 none, 1 at once, 2 inside an open bus cycle
    logic [31:0] pc;
    int          count;
    int          stall_p;  // in eighths
    int          wait_p;   // in eighths
  } phase_t;

  localparam int NPH = 8;
  localparam phase_t PHASES [NPH] = '{
    '{2'd0, 32'h0000_0000, 10, 0, 0},
    '{2'd1, 32'h0000_1104,  8, 0, 0},
    '{2'd0, 32'h0000_0000, 12, 2, 3},
    '{2'd2, 32'h0000_11fc, 10, 0, 6},
    '{2'd0, 32'h0000_0000, 20, 6, 0},
    '{2'd0, 32'h0000_0000, 20, 0, 6},
    '{2'd1, 32'h0000_1040, 16, 4, 4},
    '{2'd2, 32'h0000_1008, 12, 3, 5}
  };

  // odd number of opcode patterns so each lands in both slots
  localparam int NPAT = 7;
  localparam logic [5:0] OPCODES [NPAT] = '{`FE_OP_ALU_RR, `FE_OP_ALU_RI,
    `FE_OP_STORE, `FE_OP_BRANCH, `FE_OP_BL, 6'b111111, 6'b000001};

  logic            clk;
  logic            rst_n;
  logic            redirect;
  logic [31:0]     redirect_pc;
  logic            wb_cyc;
  logic            wb_stb;
  logic [31:0]     wb_adr;
  logic [63:0]     wb_dat;
  logic            wb_ack;
  logic            mem_wait;
  logic            pkg_valid;
  logic            pkg_ready;
  logic [31:0]     pkg_pc;
  logic [1:0]      pkg_mask;
  inst_cls_e [1:0] pkg_cls;
  logic [1:0]      pkg_ine;
  logic [1:0][4:0] pkg_r0;
  logic [1:0][4:0] pkg_r1;
  logic [1:0][4:0] pkg_w;

  logic [63:0] image [64];
  logic [15:0] lfsr_q;
  logic [31:0] exp_pc;
  logic [1:0]  exp_mask;
  int          cur_stall_p;
  int          cur_wait_p;
  int          checked;
  int          errors;

  tb_clkgen clkgen_i (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  tb_wb_mem mem_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .image_i  (image),
    .wait_i   (mem_wait),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_adr_i (wb_adr),
    .wb_dat_o (wb_dat),
    .wb_ack_o (wb_ack)
  );

  fe_top dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .wb_cyc_o      (wb_cyc),
    .wb_stb_o      (wb_stb),
    .wb_adr_o      (wb_adr),
    .wb_dat_i      (wb_dat),
    .wb_ack_i      (wb_ack),
    .pkg_valid_o   (pkg_valid),
    .pkg_ready_i   (pkg_ready),
    .pkg_pc_o      (pkg_pc),
    .pkg_mask_o    (pkg_mask),
    .pkg_cls_o     (pkg_cls),
    .pkg_ine_o     (pkg_ine),
    .pkg_r0_o      (pkg_r0),
    .pkg_r1_o      (pkg_r1),
    .pkg_w_o       (pkg_w)
  );

  // galois lfsr x^16+x^14+x^13+x^11+1 stepped once per bit
  function automatic int rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++)
    begin
      r = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hb400) : (lfsr_q >> 1);
    end
    return int'(r);
  endfunction

  function automatic int total_packets();
    int n;
    n = 0;
    for (int p = 0; p < NPH; p++)
      n += PHASES[p].count;
    return n;
  endfunction

  task automatic fill_image();
    logic [31:0] inst;
    for (int i = 0; i < 64; i++)
      for (int s = 0; s < 2; s++)
      begin
        inst[31:26] = OPCODES[(2 * i + s) % NPAT];
        inst[25:0]  = 26'(rand_bits(26));
        image[i][32*s +: 32] = inst;
      end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("** Error @ %0t ns: %s", $time, msg);
  endtask

  // register usage per instruction class
  task automatic expect_slot(input logic [31:0] inst, output inst_cls_e cls,
                             output logic ine, output logic [4:0] r0,
                             output logic [4:0] r1, output logic [4:0] w);
    logic [5:0] op;
    op  = inst[31:26];
    ine = 1'b0;
    r0  = 5'd0;
    r1  = 5'd0;
    w   = 5'd0;
    cls = CLS_ILLEGAL;
    if (op == `FE_OP_ALU_RR)
    begin
      cls = CLS_ALU_RR;
      r0  = inst[14:10];
      r1  = inst[9:5];
      w   = inst[4:0];
    end
    else if (op == `FE_OP_ALU_RI)
    begin
      cls = CLS_ALU_RI;
      r1  = inst[9:5];
      w   = inst[4:0];
    end
    else if (op == `FE_OP_STORE)
    begin
      cls = CLS_STORE;
      r0  = inst[4:0];
      r1  = inst[9:5];
    end
    else if (op == `FE_OP_BRANCH)
    begin
      cls = CLS_BRANCH;
      r0  = inst[4:0];
      r1  = inst[9:5];
    end
    else if (op == `FE_OP_BL)
    begin
      cls = CLS_BL;
      w   = 5'd1;
    end
    else
      ine = 1'b1;
  endtask

  task automatic check_packet();
    logic [63:0] word;
    inst_cls_e   cls;
    logic        ine;
    logic [4:0]  r0;
    logic [4:0]  r1;
    logic [4:0]  w;
    word = image[exp_pc[8:3]];
    assert (pkg_pc == exp_pc)
    else
      report_error($sformatf("pc %h, expected %h", pkg_pc, exp_pc));
    assert (pkg_mask == exp_mask)
    else
      report_error($sformatf("pc %h mask %b, expected %b", exp_pc, pkg_mask, exp_mask));
    for (int s = 0; s < 2; s++)
    begin
      if (exp_mask[s])
      begin
        expect_slot(word[32*s +: 32], cls, ine, r0, r1, w);
        assert (pkg_cls[s] == cls && pkg_ine[s] == ine)
        else
          report_error($sformatf("pc %h slot %0d class %0d ine %b, expected %0d %b",
                                 exp_pc, s, pkg_cls[s], pkg_ine[s], cls, ine));
        assert (pkg_r0[s] == r0 && pkg_r1[s] == r1 && pkg_w[s] == w)
        else
          report_error($sformatf("pc %h slot %0d regs %0d %0d %0d, expected %0d %0d %0d",
                                 exp_pc, s, pkg_r0[s], pkg_r1[s], pkg_w[s], r0, r1, w));
      end
    end
    checked++;
    exp_pc   = exp_pc + 32'd8;
    exp_mask = 2'b11;
  endtask

  // one clock of stimulus driven on the falling edge
  task automatic cycle_step(input logic want_redir, input logic need_cyc,
                            input logic [31:0] target, output logic fired);
    @(negedge clk);
    fired    = want_redir && (!need_cyc || wb_cyc);
    redirect = fired;
    if (fired)
      redirect_pc = target;
    pkg_ready = (rand_bits(3) >= cur_stall_p);
    mem_wait  = (rand_bits(3) < cur_wait_p);
    if (pkg_valid && pkg_ready)
      check_packet();
    // a beat taken on the redirect edge is still on the old path
    if (fired)
    begin
      exp_pc   = {target[31:3], 3'b000};
      exp_mask = target[2] ? 2'b10 : 2'b11;
    end
  endtask

  initial
  begin
    logic fired;
    int   target;
    redirect    = 1'b0;
    redirect_pc = '0;
    pkg_ready   = 1'b0;
    mem_wait    = 1'b0;
    lfsr_q      = 16'd62;
    errors      = 0;
    checked     = 0;
    cur_stall_p = 0;
    cur_wait_p  = 0;
    exp_pc      = `FE_RESET_PC;
    exp_mask    = 2'b11;
    fill_image();

    @(posedge clk);
    repeat (4)
    begin
      @(negedge clk);
      assert (!pkg_valid && !wb_cyc && !wb_stb)
      else
        report_error($sformatf("in reset pkg_valid %b wb_cyc %b wb_stb %b",
                               pkg_valid, wb_cyc, wb_stb));
    end

    for (int p = 0; p < NPH; p++)
    begin
      cur_stall_p = PHASES[p].stall_p;
      cur_wait_p  = PHASES[p].wait_p;
      if (PHASES[p].redir != 2'd0)
      begin
        fired = 1'b0;
        while (!fired)
          cycle_step(1'b1, PHASES[p].redir == 2'd2, PHASES[p].pc, fired);
      end
      target = checked + PHASES[p].count;
      while (checked < target)
        cycle_step(1'b0, 1'b0, 32'h0, fired);
    end

    $display("checked %0d packets, %0d errors", checked, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

  initial
  begin : watchdog
    #(total_packets() * CYC_PER_PKT * CLK_NS);
    $display("timeout: the packet stream stopped before all phases were done");
    $display("checked %0d packets, %0d errors", checked, errors);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

/* sim.f */
+incdir+include
rtl/fe_pkg.sv
rtl/fe_ctrl.sv
rtl/fe_pcgen.sv
rtl/fe_skid_buf.sv
rtl/fe_wb_fetch.sv
rtl/fe_decode.sv
rtl/fe_pkt_fifo.sv
rtl/fe_top.sv
testbench/tb_clkgen.sv
testbench/tb_wb_mem.sv
testbench/tb_fe_top.sv

/* run.sh */
#!/bin/sh
# build and run the fetch frontend testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f sim.f --top-module tb_fe_top \
  -Mdir "$OBJ" -o sim_fe_top
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

"./$OBJ/sim_fe_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
  exit 0
fi
exit 1
